//--- ee_macros.svh
`ifndef EE_MACROS_SVH
`define EE_MACROS_SVH

// 24C16 style device type code, top nibble of every control byte
`define EE_DEV_CODE 4'b1010

// 2K bytes, upper three bits go in the control byte
`define EE_ADDR_W 11

// clk cycles per bus bit, half with scl low and half with scl high
`define EE_BIT_CYCLES 4

`endif

//--- ee_pkg.sv
`include "ee_macros.svh"

package ee_pkg;

    typedef struct packed {
        logic                  is_read;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } ee_cmd_t;

    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] page; // addr bits 10:8
        logic       rnw;
    } ee_ctrl_fields_t;

    // built by fields, shifted out as a byte
    typedef union packed {
        ee_ctrl_fields_t f;
        logic [7:0]      raw;
    } ee_ctrl_byte_u;

    typedef enum logic [2:0] {
        op_start,   // start and repeated start
        op_stop,
        op_tx,      // master nack is op_tx with a 1
        op_rx_data,
        op_rx_ack
    } ee_op_kind_e;

    typedef struct packed {
        ee_op_kind_e kind;
        logic        bit_val;
    } ee_bit_op_t;

    typedef struct packed {
        ee_op_kind_e kind;
        logic        rx_bit;
    } ee_bit_res_t;

endpackage

//--- ee_cmd_latch.sv
`include "ee_macros.svh"

module ee_cmd_latch (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    input  logic                  frame_end,
    output ee_pkg::ee_cmd_t       cmd,
    output logic                  cmd_valid,
    output logic                  busy
);

    logic accept;

    assign accept = ~cmd_valid & (wr | rd); // strobes while busy are dropped
    assign busy   = cmd_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            cmd_valid <= 1'b0;
        else if (frame_end)
            cmd_valid <= 1'b0;
        else if (accept)
            cmd_valid <= 1'b1;
    end

    // held for the whole frame, outside may move on
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd.is_read <= ~wr; // wr wins over rd
            cmd.addr    <= addr;
            cmd.wdata   <= wdata;
        end
    end

endmodule

//--- ee_frame_seq.sv
`include "ee_macros.svh"

module ee_frame_seq (
    input  logic               CLK,
    input  logic               RESET,
    input  ee_pkg::ee_cmd_t    cmd,
    input  logic               cmd_valid,
    input  logic               op_done,
    output ee_pkg::ee_bit_op_t op,
    output logic               op_go,
    output logic               frame_end
);

    import ee_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_w,
        st_addr,
        st_data_w,
        st_rstart,
        st_ctrl_r,
        st_data_r,
        st_stop
    } state_e;

    state_e        state;
    state_e        nstate;
    logic [3:0]    cnt;    // bit within a byte phase, 8 is the ack slot
    logic [3:0]    ncnt;
    logic          advance;
    ee_ctrl_byte_u ctrl;
    logic [7:0]    byte_sel;
    logic [7:0]    tx_src;
    logic [7:0]    sh;
    ee_bit_op_t    nop;

    always_comb
    begin
        // frame_end still high blocks a restart on the old cmd_valid
        advance = (state == st_idle) ? (cmd_valid & ~frame_end) : op_done;
        nstate  = state;
        ncnt    = '0;
        case (state)
            st_idle:   nstate = st_start;
            st_start:  nstate = st_ctrl_w;
            st_rstart: nstate = st_ctrl_r;
            st_stop:   nstate = st_idle;
            default:
            begin
                if (cnt != 4'd8)
                    ncnt = cnt + 4'd1;
                else
                begin
                    case (state)
                        st_ctrl_w: nstate = st_addr;
                        st_addr:   nstate = cmd.is_read ? st_rstart : st_data_w;
                        st_ctrl_r: nstate = st_data_r;
                        default:   nstate = st_stop;
                    endcase
                end
            end
        endcase

        ctrl.f.dev  = `EE_DEV_CODE;
        ctrl.f.page = cmd.addr[`EE_ADDR_W-1:8];
        ctrl.f.rnw  = (nstate == st_ctrl_r);

        case (nstate)
            st_ctrl_w, st_ctrl_r: byte_sel = ctrl.raw;
            st_addr:              byte_sel = cmd.addr[7:0];
            default:              byte_sel = cmd.wdata;
        endcase
        tx_src = (ncnt == 4'd0) ? byte_sel : sh; // load at first bit of a byte

        nop.kind    = op_tx;
        nop.bit_val = 1'b0;
        case (nstate)
            st_start, st_rstart: nop.kind = op_start;
            st_stop:             nop.kind = op_stop;
            st_data_r:
            begin
                if (ncnt == 4'd8)
                    nop.bit_val = 1'b1; // master nack ends the read
                else
                    nop.kind = op_rx_data;
            end
            default:
            begin
                if (ncnt == 4'd8)
                    nop.kind = op_rx_ack;
                else
                    nop.bit_val = tx_src[7];
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= st_idle;
            cnt       <= '0;
            op_go     <= 1'b0;
            frame_end <= 1'b0;
        end
        else
        begin
            op_go     <= 1'b0;
            frame_end <= 1'b0;
            if (advance)
            begin
                state     <= nstate;
                cnt       <= ncnt;
                op_go     <= (nstate != st_idle);
                frame_end <= (nstate == st_idle); // stop op just finished
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            op <= nop;
            sh <= {tx_src[6:0], 1'b0};
        end
    end

endmodule

//--- ee_bit_engine.sv
`include "ee_macros.svh"

module ee_bit_engine (
    input  logic                CLK,
    input  logic                RESET,
    input  ee_pkg::ee_bit_op_t  op,
    input  logic                op_go,
    input  logic                sda_in,
    output logic                scl,
    output logic                sda_low,
    output logic                op_done,
    output ee_pkg::ee_bit_res_t res
);

    import ee_pkg::*;

    localparam int PH_W    = $clog2(`EE_BIT_CYCLES);
    localparam int PH_HI   = `EE_BIT_CYCLES / 2;  // first scl high phase
    localparam int PH_LAST = `EE_BIT_CYCLES - 1;

    logic            active;
    logic [PH_W-1:0] phase;
    ee_bit_op_t      cur;
    logic            scl_q;
    logic            sda_q;
    logic            run;
    logic [PH_W-1:0] ph;
    ee_op_kind_e     kind;
    logic            bit_val;
    logic            scl_n;
    logic            sda_n;

    // phase 0 runs in the op_go cycle itself
    always_comb
    begin
        run     = op_go | active;
        kind    = op_go ? op.kind : cur.kind;
        bit_val = op_go ? op.bit_val : cur.bit_val;
        ph      = op_go ? '0 : phase;
        scl_n   = scl_q; // hold between ops
        sda_n   = sda_q;
        if (run)
        begin
            case (kind)
                op_start:
                begin
                    if (ph == 0)
                    begin
                        scl_n = 1'b0;
                        sda_n = 1'b0;
                    end
                    else if (ph == 1)
                        scl_n = 1'b1;
                    else if (ph == PH_HI)
                        sda_n = 1'b1;  // sda falls with scl high
                    else if (ph == PH_LAST)
                        scl_n = 1'b0;
                end
                op_stop:
                begin
                    if (ph == 0)
                        scl_n = 1'b0;
                    else if (ph == 1)
                        sda_n = 1'b1;
                    else if (ph == PH_HI)
                        scl_n = 1'b1;
                    else if (ph == PH_LAST)
                        sda_n = 1'b0;  // sda rises with scl high
                end
                default:
                begin
                    if (ph == 0)
                        scl_n = 1'b0;
                    else if (ph == 1)
                        sda_n = (kind == op_tx) ? ~bit_val : 1'b0;
                    else if (ph == PH_HI)
                        scl_n = 1'b1;
                end
            endcase
        end
    end

    assign scl     = scl_n;
    assign sda_low = sda_n;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            phase   <= '0;
            scl_q   <= 1'b1;   // idle bus
            sda_q   <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            scl_q   <= scl_n;
            sda_q   <= sda_n;
            op_done <= 1'b0;
            if (op_go)
            begin
                active <= 1'b1;
                phase  <= PH_W'(1);
            end
            else if (active)
            begin
                phase <= phase + 1'b1;
                if (phase == PH_LAST)
                begin
                    active  <= 1'b0;
                    op_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_go)
            cur <= op;
        if (run && ph == PH_LAST)
        begin
            res.kind   <= kind;
            res.rx_bit <= sda_in; // second scl high cycle
        end
    end

endmodule

//--- ee_result.sv
module ee_result (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_done,
    input  ee_pkg::ee_bit_res_t res,
    input  logic                frame_end,
    output logic [7:0]          rdata,
    output logic                nack,
    output logic                done
);

    import ee_pkg::*;

    logic [7:0] shift;
    logic       nack_seen;

    always_ff @(posedge CLK)
    begin
        if (op_done && res.kind == op_rx_data)
            shift <= {shift[6:0], res.rx_bit}; // msb first
        if (frame_end)
            rdata <= shift;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            nack_seen <= 1'b0;
            nack      <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done <= frame_end;
            if (frame_end)
            begin
                nack      <= nack_seen;
                nack_seen <= 1'b0; // fresh for next frame
            end
            else if (op_done && res.kind == op_rx_ack && res.rx_bit)
                nack_seen <= 1'b1;
        end
    end

endmodule

//--- ee_ctrl_top.sv
`include "ee_macros.svh"

module ee_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    input  logic                  sda_in,
    output logic                  scl,
    output logic                  sda_low,
    output logic                  busy,
    output logic                  done,
    output logic [7:0]            rdata,
    output logic                  nack
);

    import ee_pkg::*;

    ee_cmd_t     cmd;
    logic        cmd_valid;
    ee_bit_op_t  op;
    logic        op_go;
    logic        op_done;
    ee_bit_res_t res;
    logic        frame_end;

    ee_cmd_latch u_cmd_latch (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .frame_end (frame_end),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .busy      (busy)
    );

    ee_frame_seq u_frame_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .op_done   (op_done),
        .op        (op),
        .op_go     (op_go),
        .frame_end (frame_end)
    );

    ee_bit_engine u_bit_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .op      (op),
        .op_go   (op_go),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_low (sda_low),
        .op_done (op_done),
        .res     (res)
    );

    ee_result u_result (
        .CLK       (CLK),
        .RESET     (RESET),
        .op_done   (op_done),
        .res       (res),
        .frame_end (frame_end),
        .rdata     (rdata),
        .nack      (nack),
        .done      (done)
    );

endmodule

//--- tb_eeprom_model.sv
`include "ee_macros.svh"

module tb_eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic busy,
    output logic sda_pull
);

    timeunit 1ns;
    timeprecision 1ns;

    typedef enum logic [1:0] {m_idle, m_recv, m_send} mode_e;

    logic [7:0]  mem [0:2047];
    mode_e       mode;
    logic        scl_d;
    logic        sda_d;
    logic [3:0]  cnt;      // 8 is the ack slot
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [2:0]  page;
    logic [10:0] ptr;
    logic [7:0]  rbyte;
    logic        ack_next;
    logic        go_send;

    // low byte xor 5a with the page bits folded in
    function automatic logic [7:0] fill_value(input int a);
        return a[7:0] ^ 8'h5A ^ {5'd0, a[10:8]};
    endfunction

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = fill_value(i);
        mode     = m_idle;
        sda_pull = 1'b0;
        scl_d    = 1'b1;
        sda_d    = 1'b1;
        cnt      = '0;
        byte_idx = '0;
        shreg    = '0;
        page     = '0;
        ptr      = '0;
        rbyte    = '0;
        ack_next = 1'b0;
        go_send  = 1'b0;
    end

    // bus sampled mid cycle, edges found against the last sample
    always @(negedge CLK)
    begin
        if (scl_d && scl && sda_d && !sda)
        begin
            mode     = m_recv; // start or repeated start
            cnt      = '0;
            byte_idx = '0;
            go_send  = 1'b0;
            sda_pull = 1'b0;
        end
        else if (scl_d && scl && !sda_d && sda)
            mode = m_idle;     // stop
        else if (!scl_d && scl)
        begin
            if (mode == m_recv && cnt < 4'd8)
            begin
                shreg = {shreg[6:0], sda};
                cnt   = cnt + 4'd1;
                if (cnt == 4'd8)
                begin
                    case (byte_idx)
                        2'd0:
                        begin
                            ack_next = (shreg[7:4] == `EE_DEV_CODE) && !busy;
                            page     = shreg[3:1];
                            go_send  = shreg[0];
                            byte_idx = 2'd1;
                        end
                        2'd1:
                        begin
                            ptr      = {page, shreg};
                            ack_next = 1'b1;
                            byte_idx = 2'd2;
                        end
                        default:
                        begin
                            mem[ptr] = shreg;
                            ptr      = ptr + 11'd1;
                            ack_next = 1'b1;
                        end
                    endcase
                end
            end
            else if (mode == m_recv)
            begin
                cnt = '0; // ack clock done
                if (!ack_next)
                    mode = m_idle;
                else if (go_send)
                begin
                    mode  = m_send;
                    rbyte = mem[ptr];
                end
            end
            else if (mode == m_send && cnt < 4'd8)
                cnt = cnt + 4'd1;
            else if (mode == m_send)
            begin
                if (sda)
                    mode = m_idle; // master nack
                else
                begin
                    cnt   = '0;
                    ptr   = ptr + 11'd1;
                    rbyte = mem[ptr];
                end
            end
        end
        else if (scl_d && !scl)
        begin
            case (mode)
                m_recv:  sda_pull = (cnt == 4'd8) ? ack_next : 1'b0;
                m_send:  sda_pull = (cnt == 4'd8) ? 1'b0 : ~rbyte[3'd7 - cnt[2:0]];
                default: sda_pull = 1'b0;
            endcase
        end
        scl_d = scl;
        sda_d = sda;
    end

endmodule

//--- tb_ee_ctrl.sv
`include "ee_macros.svh"

module tb_ee_ctrl;

    timeunit 1ns;
    timeprecision 1ns;

    typedef struct packed {
        logic                  is_read;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
        logic                  model_busy;
        logic                  extra_wr;  // second wr strobe while busy
    } entry_t;

    localparam int N_TESTS = 13;
    // each op plus one issue cycle, read frame is the longest
    localparam int LIMIT = N_TESTS * (39 * (`EE_BIT_CYCLES + 1) + 20);

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
    logic                  sda_in;
    logic                  scl;
    logic                  sda_low;
    logic                  busy;
    logic                  done;
    logic [7:0]            rdata;
    logic                  nack;
    logic                  model_busy;
    logic                  model_pull;
    entry_t                tests [N_TESTS];
    logic [7:0]            shadow [0:2047];
    logic [31:0]           rnd = 32'h5267;
    int                    cycles = 0;
    int                    errors = 0;
    int                    test_errors = 0;
    int                    passed = 0;
    int                    failed = 0;

    assign sda_in = ~(sda_low | model_pull); // wired-and of both open drains

    ee_ctrl_top dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_low (sda_low),
        .busy    (busy),
        .done    (done),
        .rdata   (rdata),
        .nack    (nack)
    );

    tb_eeprom_model eeprom (
        .CLK      (CLK),
        .scl      (scl),
        .sda      (sda_in),
        .busy     (model_busy),
        .sda_pull (model_pull)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout: done never arrived");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [7:0] random_byte();
        rnd = rnd * 32'd1103515245 + 32'd12345;
        return rnd[23:16];
    endfunction

    function automatic logic [7:0] fill_value(input int a);
        return a[7:0] ^ 8'h5A ^ {5'd0, a[10:8]};
    endfunction

    function automatic entry_t make_test(input logic is_read, input logic [10:0] a,
                                         input logic [7:0] d, input logic bsy,
                                         input logic extra);
        return '{is_read, a, d, bsy, extra};
    endfunction

    task automatic note_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_errors++;
        errors++;
    endtask

    task automatic build_tests();
        tests[0]  = make_test(1'b0, 11'h0A3, random_byte(), 1'b0, 1'b0);
        tests[1]  = make_test(1'b0, 11'h5A3, random_byte(), 1'b0, 1'b0); // same low byte
        tests[2]  = make_test(1'b1, 11'h0A3, 8'h00, 1'b0, 1'b0);
        tests[3]  = make_test(1'b1, 11'h5A3, 8'h00, 1'b0, 1'b0);
        tests[4]  = make_test(1'b1, 11'h123, 8'h00, 1'b0, 1'b0);
        tests[5]  = make_test(1'b0, 11'h2F0, random_byte(), 1'b1, 1'b0);
        tests[6]  = make_test(1'b1, 11'h2F0, 8'h00, 1'b0, 1'b0);
        tests[7]  = make_test(1'b0, 11'h7FF, random_byte(), 1'b0, 1'b1);
        tests[8]  = make_test(1'b1, 11'h7FF, 8'h00, 1'b0, 1'b0);
        tests[9]  = make_test(1'b1, 11'h000, 8'h00, 1'b0, 1'b0);
        tests[10] = make_test(1'b0, 11'h000, 8'hC3, 1'b0, 1'b0);
        tests[11] = make_test(1'b1, 11'h000, 8'h00, 1'b0, 1'b0);
        tests[12] = make_test(1'b1, 11'h5A3, 8'h00, 1'b1, 1'b0);
    endtask

    task automatic run_test(input int idx);
        entry_t     t;
        logic [7:0] expect_data;
        t           = tests[idx];
        test_errors = 0;
        expect_data = shadow[t.addr];
        @(negedge CLK);
        model_busy = t.model_busy;
        addr       = t.addr;
        wdata      = t.wdata;
        wr         = ~t.is_read;
        rd         = t.is_read;
        @(negedge CLK);
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = ~t.addr;  // command must already be held
        wdata = ~t.wdata;
        if (t.extra_wr)
        begin
            @(negedge CLK);
            assert (busy === 1'b1)
            else note_error($sformatf("test %0d busy low during frame", idx));
            addr = t.addr;
            wr   = 1'b1;
            @(negedge CLK);
            wr = 1'b0;
        end
        while (done !== 1'b1)
            @(negedge CLK);
        assert (nack === t.model_busy)
        else note_error($sformatf("test %0d nack %b expected %b", idx, nack, t.model_busy));
        if (t.is_read && !t.model_busy)
        begin
            assert (rdata === expect_data)
            else note_error($sformatf("test %0d rdata %h expected %h", idx, rdata, expect_data));
        end
        assert (scl === 1'b1 && sda_low === 1'b0)
        else note_error($sformatf("test %0d bus not released after frame", idx));
        if (!t.is_read && !t.model_busy)
            shadow[t.addr] = t.wdata;
        repeat (6)
        begin
            @(negedge CLK);
            assert (done === 1'b0 && busy === 1'b0)
            else note_error($sformatf("test %0d extra done pulse or busy after frame", idx));
        end
        if (test_errors == 0)
            passed++;
        else
            failed++;
        $display("test %0d %s addr %h busy %b: %s", idx, t.is_read ? "read " : "write",
                 t.addr, t.model_busy, (test_errors == 0) ? "ok" : "failed");
    endtask

    initial
    begin
        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        model_busy = 1'b0;
        for (int a = 0; a < 2048; a++)
            shadow[a] = fill_value(a);
        build_tests();
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        assert (done === 1'b0 && busy === 1'b0 && scl === 1'b1 && sda_low === 1'b0)
        else note_error("outputs not idle after reset");
        for (int i = 0; i < N_TESTS; i++)
            run_test(i);
        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
ee_pkg.sv
ee_cmd_latch.sv
ee_frame_seq.sv
ee_bit_engine.sv
ee_result.sv
ee_ctrl_top.sv
tb_eeprom_model.sv
tb_ee_ctrl.sv

//--- Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tb_ee_ctrl
FLIST  = vlog.f
OBJDIR = obj_dir
PASS   = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
